// File: Bender.yml
package:
  name: rv_core

export_include_dirs:
  - .

sources:
  - files:
      - rv_isa_pkg.sv
      - rv_core_pkg.sv
      - rv_decoder.sv
      - rv_regfile.sv
      - rv_pc_unit.sv
      - rv_execute.sv
      - rv_lsu.sv
      - rv_core.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_rv_core.sv

// File: rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_core_pkg::word_t    insn_from_imem,
  input  rv_core_pkg::word_t    load_data_from_dmem,
  output rv_core_pkg::word_t    pc_to_imem,
  output rv_core_pkg::word_t    addr_to_dmem,
  output rv_core_pkg::word_t    store_data_to_dmem,
  output rv_core_pkg::byte_en_t store_we_to_dmem,
  output logic                  halt
);

  rv_isa_pkg::reg_idx_t   rs1;
  rv_isa_pkg::reg_idx_t   rs2;
  rv_isa_pkg::reg_idx_t   rd;
  rv_isa_pkg::funct3_t    funct3;
  rv_core_pkg::word_t     imm;
  rv_core_pkg::alu_op_e   alu_op;
  logic                   alu_src_imm;
  logic                   alu_src_pc;
  rv_core_pkg::wb_sel_e   wb_sel;
  logic                   reg_we;
  logic                   is_branch;
  logic                   is_jal;
  logic                   is_jalr;
  logic                   is_load;
  logic                   is_store;
  rv_core_pkg::mem_size_e mem_size;
  logic                   load_unsigned;
  rv_core_pkg::word_t     rs1_data;
  rv_core_pkg::word_t     rs2_data;
  rv_core_pkg::word_t     pc_plus4;
  rv_core_pkg::word_t     alu_result;
  rv_core_pkg::word_t     rd_data;
  rv_core_pkg::word_t     load_value;

  rv_pc_unit i_pc_unit (
    .clk       (clk),
    .rst       (rst),
    .is_branch (is_branch),
    .is_jal    (is_jal),
    .is_jalr   (is_jalr),
    .funct3    (funct3),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .imm       (imm),
    .pc        (pc_to_imem),
    .pc_plus4  (pc_plus4)
  );

  rv_decoder i_decoder (
    .insn          (insn_from_imem),
    .rs1           (rs1),
    .rs2           (rs2),
    .rd            (rd),
    .funct3        (funct3),
    .imm           (imm),
    .alu_op        (alu_op),
    .alu_src_imm   (alu_src_imm),
    .alu_src_pc    (alu_src_pc),
    .wb_sel        (wb_sel),
    .reg_we        (reg_we),
    .is_branch     (is_branch),
    .is_jal        (is_jal),
    .is_jalr       (is_jalr),
    .is_load       (is_load),
    .is_store      (is_store),
    .mem_size      (mem_size),
    .load_unsigned (load_unsigned),
    .halt          (halt)
  );

  rv_regfile i_regfile (
    .clk      (clk),
    .rst      (rst),
    .we       (reg_we),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (rd),
    .rd_data  (rd_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_execute i_execute (
    .alu_op      (alu_op),
    .alu_src_imm (alu_src_imm),
    .alu_src_pc  (alu_src_pc),
    .wb_sel      (wb_sel),
    .pc          (pc_to_imem),
    .pc_plus4    (pc_plus4),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .imm         (imm),
    .load_value  (load_value),
    .alu_result  (alu_result),
    .rd_data     (rd_data)
  );

  rv_lsu i_lsu (
    .is_load             (is_load),
    .is_store            (is_store),
    .load_unsigned       (load_unsigned),
    .mem_size            (mem_size),
    .alu_result          (alu_result),
    .rs2_data            (rs2_data),
    .load_data_from_dmem (load_data_from_dmem),
    .addr_to_dmem        (addr_to_dmem),
    .store_data_to_dmem  (store_data_to_dmem),
    .store_we_to_dmem    (store_we_to_dmem),
    .load_value          (load_value)
  );

endmodule

`default_nettype wire

// File: rv_core_pkg.sv
`default_nettype none

`include "rv_settings.svh"

package rv_core_pkg;

  typedef logic [`RV_XLEN-1:0]   word_t;
  typedef logic [`RV_XLEN/8-1:0] byte_en_t;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    // operand b straight through, for lui
    alu_pass_b
  } alu_op_e;

  // register write source
  typedef enum logic [1:0] {
    wb_alu,
    wb_load,
    wb_link
  } wb_sel_e;

  typedef enum logic [1:0] {
    size_byte,
    size_half,
    size_word
  } mem_size_e;

endpackage

`default_nettype wire

// File: rv_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module rv_decoder (
  input  rv_core_pkg::word_t     insn,
  output rv_isa_pkg::reg_idx_t   rs1,
  output rv_isa_pkg::reg_idx_t   rs2,
  output rv_isa_pkg::reg_idx_t   rd,
  output rv_isa_pkg::funct3_t    funct3,
  output rv_core_pkg::word_t     imm,
  output rv_core_pkg::alu_op_e   alu_op,
  output logic                   alu_src_imm,
  output logic                   alu_src_pc,
  output rv_core_pkg::wb_sel_e   wb_sel,
  output logic                   reg_we,
  output logic                   is_branch,
  output logic                   is_jal,
  output logic                   is_jalr,
  output logic                   is_load,
  output logic                   is_store,
  output rv_core_pkg::mem_size_e mem_size,
  output logic                   load_unsigned,
  output logic                   halt
);

  rv_isa_pkg::opcode_t  opcode;
  logic [6:0]           funct7;
  logic                 funct7_ok;
  logic                 is_shift;
  rv_core_pkg::alu_op_e alu_fn;
  rv_core_pkg::word_t   imm_i;
  rv_core_pkg::word_t   imm_s;
  rv_core_pkg::word_t   imm_b;
  rv_core_pkg::word_t   imm_u;
  rv_core_pkg::word_t   imm_j;

  assign opcode = insn[6:0];
  assign rd     = insn[11:7];
  assign funct3 = insn[14:12];
  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];
  assign funct7 = insn[31:25];

  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};
  assign imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};

  // only sub and the right shifts may use the alternate funct7
  assign is_shift  = funct3 == rv_isa_pkg::f3_sll || funct3 == rv_isa_pkg::f3_sr;
  assign funct7_ok = funct7 == 7'b0 ||
                     (funct7 == rv_isa_pkg::funct7_alt &&
                      (funct3 == rv_isa_pkg::f3_sr ||
                       (funct3 == rv_isa_pkg::f3_add && opcode == rv_isa_pkg::op_reg)));

  always_comb begin
    case (funct3)
      rv_isa_pkg::f3_add: begin
        alu_fn = (opcode == rv_isa_pkg::op_reg && insn[30]) ? rv_core_pkg::alu_sub
                                                             : rv_core_pkg::alu_add;
      end
      rv_isa_pkg::f3_sll:  alu_fn = rv_core_pkg::alu_sll;
      rv_isa_pkg::f3_slt:  alu_fn = rv_core_pkg::alu_slt;
      rv_isa_pkg::f3_sltu: alu_fn = rv_core_pkg::alu_sltu;
      rv_isa_pkg::f3_xor:  alu_fn = rv_core_pkg::alu_xor;
      rv_isa_pkg::f3_sr:   alu_fn = insn[30] ? rv_core_pkg::alu_sra : rv_core_pkg::alu_srl;
      rv_isa_pkg::f3_or:   alu_fn = rv_core_pkg::alu_or;
      default:             alu_fn = rv_core_pkg::alu_and;
    endcase
  end

  // anything not matched below retires with no side effect
  always_comb begin
    imm           = '0;
    alu_op        = rv_core_pkg::alu_add;
    alu_src_imm   = 1'b0;
    alu_src_pc    = 1'b0;
    wb_sel        = rv_core_pkg::wb_alu;
    reg_we        = 1'b0;
    is_branch     = 1'b0;
    is_jal        = 1'b0;
    is_jalr       = 1'b0;
    is_load       = 1'b0;
    is_store      = 1'b0;
    mem_size      = rv_core_pkg::size_word;
    load_unsigned = 1'b0;
    halt          = 1'b0;
    case (opcode)
      rv_isa_pkg::op_lui: begin
        imm         = imm_u;
        alu_op      = rv_core_pkg::alu_pass_b;
        alu_src_imm = 1'b1;
        reg_we      = 1'b1;
      end
      rv_isa_pkg::op_auipc: begin
        imm         = imm_u;
        alu_src_imm = 1'b1;
        alu_src_pc  = 1'b1;
        reg_we      = 1'b1;
      end
      rv_isa_pkg::op_jal: begin
        imm    = imm_j;
        is_jal = 1'b1;
        wb_sel = rv_core_pkg::wb_link;
        reg_we = 1'b1;
      end
      rv_isa_pkg::op_jalr: begin
        imm = imm_i;
        if (funct3 == 3'b000) begin
          is_jalr = 1'b1;
          wb_sel  = rv_core_pkg::wb_link;
          reg_we  = 1'b1;
        end
      end
      rv_isa_pkg::op_branch: begin
        imm = imm_b;
        // funct3 010 and 011 are not branches
        is_branch = funct3[2:1] != 2'b01;
      end
      rv_isa_pkg::op_load: begin
        imm           = imm_i;
        alu_src_imm   = 1'b1;
        wb_sel        = rv_core_pkg::wb_load;
        load_unsigned = funct3[2];
        case (funct3)
          rv_isa_pkg::f3_mem_b, rv_isa_pkg::f3_mem_bu: mem_size = rv_core_pkg::size_byte;
          rv_isa_pkg::f3_mem_h, rv_isa_pkg::f3_mem_hu: mem_size = rv_core_pkg::size_half;
          default:                                     mem_size = rv_core_pkg::size_word;
        endcase
        is_load = funct3 != 3'b011 && funct3[2:1] != 2'b11;
        reg_we  = is_load;
      end
      rv_isa_pkg::op_store: begin
        imm         = imm_s;
        alu_src_imm = 1'b1;
        case (funct3)
          rv_isa_pkg::f3_mem_b: mem_size = rv_core_pkg::size_byte;
          rv_isa_pkg::f3_mem_h: mem_size = rv_core_pkg::size_half;
          default:              mem_size = rv_core_pkg::size_word;
        endcase
        is_store = funct3[2] == 1'b0 && funct3 != 3'b011;
      end
      rv_isa_pkg::op_imm: begin
        imm         = imm_i;
        alu_op      = alu_fn;
        alu_src_imm = 1'b1;
        reg_we      = !is_shift || funct7_ok;
      end
      rv_isa_pkg::op_reg: begin
        alu_op = alu_fn;
        reg_we = funct7_ok;
      end
      rv_isa_pkg::op_system: begin
        // ecall only, every other system encoding is a no-op
        halt = insn[31:7] == 25'b0;
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

// File: rv_execute.sv
`timescale 1ns/10ps
`default_nettype none

module rv_execute (
  input  rv_core_pkg::alu_op_e alu_op,
  input  logic                 alu_src_imm,
  input  logic                 alu_src_pc,
  input  rv_core_pkg::wb_sel_e wb_sel,
  input  rv_core_pkg::word_t   pc,
  input  rv_core_pkg::word_t   pc_plus4,
  input  rv_core_pkg::word_t   rs1_data,
  input  rv_core_pkg::word_t   rs2_data,
  input  rv_core_pkg::word_t   imm,
  input  rv_core_pkg::word_t   load_value,
  output rv_core_pkg::word_t   alu_result,
  output rv_core_pkg::word_t   rd_data
);

  rv_core_pkg::word_t op_a;
  rv_core_pkg::word_t op_b;
  logic [4:0]         shamt;

  // pc as operand a only for auipc
  assign op_a  = alu_src_pc ? pc : rs1_data;
  assign op_b  = alu_src_imm ? imm : rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (alu_op)
      rv_core_pkg::alu_add:    alu_result = op_a + op_b;
      rv_core_pkg::alu_sub:    alu_result = op_a - op_b;
      rv_core_pkg::alu_sll:    alu_result = op_a << shamt;
      rv_core_pkg::alu_slt:    alu_result = rv_core_pkg::word_t'($signed(op_a) < $signed(op_b));
      rv_core_pkg::alu_sltu:   alu_result = rv_core_pkg::word_t'(op_a < op_b);
      rv_core_pkg::alu_xor:    alu_result = op_a ^ op_b;
      rv_core_pkg::alu_srl:    alu_result = op_a >> shamt;
      rv_core_pkg::alu_sra:    alu_result = rv_core_pkg::word_t'($signed(op_a) >>> shamt);
      rv_core_pkg::alu_or:     alu_result = op_a | op_b;
      rv_core_pkg::alu_and:    alu_result = op_a & op_b;
      rv_core_pkg::alu_pass_b: alu_result = op_b;
      default:                 alu_result = '0;
    endcase
  end

  // write-back source
  always_comb begin
    case (wb_sel)
      rv_core_pkg::wb_load: rd_data = load_value;
      rv_core_pkg::wb_link: rd_data = pc_plus4;
      default:              rd_data = alu_result;
    endcase
  end

endmodule

`default_nettype wire

// File: rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  typedef logic [4:0] reg_idx_t;
  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;

  // major opcodes of the kept instructions
  localparam opcode_t op_lui    = 7'b0110111;
  localparam opcode_t op_auipc  = 7'b0010111;
  localparam opcode_t op_jal    = 7'b1101111;
  localparam opcode_t op_jalr   = 7'b1100111;
  localparam opcode_t op_branch = 7'b1100011;
  localparam opcode_t op_load   = 7'b0000011;
  localparam opcode_t op_store  = 7'b0100011;
  localparam opcode_t op_imm    = 7'b0010011;
  localparam opcode_t op_reg    = 7'b0110011;
  localparam opcode_t op_system = 7'b1110011;

  // branch conditions
  localparam funct3_t f3_beq  = 3'b000;
  localparam funct3_t f3_bne  = 3'b001;
  localparam funct3_t f3_blt  = 3'b100;
  localparam funct3_t f3_bge  = 3'b101;
  localparam funct3_t f3_bltu = 3'b110;
  localparam funct3_t f3_bgeu = 3'b111;

  // load and store widths, bit 2 marks the unsigned loads
  localparam funct3_t f3_mem_b  = 3'b000;
  localparam funct3_t f3_mem_h  = 3'b001;
  localparam funct3_t f3_mem_w  = 3'b010;
  localparam funct3_t f3_mem_bu = 3'b100;
  localparam funct3_t f3_mem_hu = 3'b101;

  // alu operations
  localparam funct3_t f3_add  = 3'b000;
  localparam funct3_t f3_sll  = 3'b001;
  localparam funct3_t f3_slt  = 3'b010;
  localparam funct3_t f3_sltu = 3'b011;
  localparam funct3_t f3_xor  = 3'b100;
  localparam funct3_t f3_sr   = 3'b101;
  localparam funct3_t f3_or   = 3'b110;
  localparam funct3_t f3_and  = 3'b111;

  // funct7 of sub and sra
  localparam logic [6:0] funct7_alt = 7'b0100000;

endpackage

`default_nettype wire

// File: rv_lsu.sv
`timescale 1ns/10ps
`default_nettype none

module rv_lsu (
  input  logic                   is_load,
  input  logic                   is_store,
  input  logic                   load_unsigned,
  input  rv_core_pkg::mem_size_e mem_size,
  input  rv_core_pkg::word_t     alu_result,
  input  rv_core_pkg::word_t     rs2_data,
  input  rv_core_pkg::word_t     load_data_from_dmem,
  output rv_core_pkg::word_t     addr_to_dmem,
  output rv_core_pkg::word_t     store_data_to_dmem,
  output rv_core_pkg::byte_en_t  store_we_to_dmem,
  output rv_core_pkg::word_t     load_value
);

  logic [1:0]  offset;
  logic [7:0]  load_byte;
  logic [15:0] load_half;

  assign offset       = alu_result[1:0];
  assign addr_to_dmem = {alu_result[31:2], 2'b00};

  // lanes carry copies of the byte or half, strobes pick the one written
  always_comb begin
    store_we_to_dmem = '0;
    case (mem_size)
      rv_core_pkg::size_byte: begin
        store_data_to_dmem = {4{rs2_data[7:0]}};
        store_we_to_dmem   = 4'b0001 << offset;
      end
      rv_core_pkg::size_half: begin
        store_data_to_dmem = {2{rs2_data[15:0]}};
        store_we_to_dmem   = offset[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        store_data_to_dmem = rs2_data;
        store_we_to_dmem   = 4'b1111;
      end
    endcase
    if (!is_store) begin
      store_we_to_dmem = '0;
    end
  end

  assign load_byte = load_data_from_dmem[8*offset +: 8];
  assign load_half = offset[1] ? load_data_from_dmem[31:16] : load_data_from_dmem[15:0];

  always_comb begin
    case (mem_size)
      rv_core_pkg::size_byte: begin
        load_value = {{24{load_byte[7] & !load_unsigned}}, load_byte};
      end
      rv_core_pkg::size_half: begin
        load_value = {{16{load_half[15] & !load_unsigned}}, load_half};
      end
      default: load_value = load_data_from_dmem;
    endcase
  end

  // the memory ignores the low address bits, so misaligned data would be silently wrong
  always_comb begin
    if (is_load || is_store) begin
      mem_aligned: assert final (mem_size == rv_core_pkg::size_byte ||
                                 (mem_size == rv_core_pkg::size_half && !offset[0]) ||
                                 offset == 2'b00)
        else $error("misaligned access at %h", alu_result);
    end
  end

endmodule

`default_nettype wire

// File: rv_pc_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_settings.svh"

module rv_pc_unit (
  input  logic                clk,
  input  logic                rst,
  input  logic                is_branch,
  input  logic                is_jal,
  input  logic                is_jalr,
  input  rv_isa_pkg::funct3_t funct3,
  input  rv_core_pkg::word_t  rs1_data,
  input  rv_core_pkg::word_t  rs2_data,
  input  rv_core_pkg::word_t  imm,
  output rv_core_pkg::word_t  pc,
  output rv_core_pkg::word_t  pc_plus4
);

  rv_core_pkg::word_t pc_next;
  rv_core_pkg::word_t target;
  rv_core_pkg::word_t jalr_sum;
  logic               taken;

  always_comb begin
    case (funct3)
      rv_isa_pkg::f3_beq:  taken = rs1_data == rs2_data;
      rv_isa_pkg::f3_bne:  taken = rs1_data != rs2_data;
      rv_isa_pkg::f3_blt:  taken = $signed(rs1_data) < $signed(rs2_data);
      rv_isa_pkg::f3_bge:  taken = $signed(rs1_data) >= $signed(rs2_data);
      rv_isa_pkg::f3_bltu: taken = rs1_data < rs2_data;
      rv_isa_pkg::f3_bgeu: taken = rs1_data >= rs2_data;
      default:             taken = 1'b0;
    endcase
  end

  assign pc_plus4 = pc + 32'd4;
  assign target   = pc + imm;
  assign jalr_sum = rs1_data + imm;

  always_comb begin
    if (is_jalr) begin
      pc_next = {jalr_sum[`RV_XLEN-1:1], 1'b0};
    end else if (is_jal || (is_branch && taken)) begin
      pc_next = target;
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `RV_RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

  // a jalr or branch to a halfword target would break fetch
  pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else $error("misaligned pc %h", pc);

endmodule

`default_nettype wire

// File: rv_regfile.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_settings.svh"

module rv_regfile (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 we,
  input  rv_isa_pkg::reg_idx_t rs1,
  input  rv_isa_pkg::reg_idx_t rs2,
  input  rv_isa_pkg::reg_idx_t rd,
  input  rv_core_pkg::word_t   rd_data,
  output rv_core_pkg::word_t   rs1_data,
  output rv_core_pkg::word_t   rs2_data
);

  rv_core_pkg::word_t regs [`RV_NUM_REGS];

  // x0 is cleared here and never written afterwards
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  x0_reads_zero: assert property (@(posedge clk) disable iff (rst)
    (rs1 != '0 || rs1_data == '0) && (rs2 != '0 || rs2_data == '0))
    else $error("x0 read returned a nonzero value");

endmodule

`default_nettype wire

// File: rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// data and address width
`define RV_XLEN 32

// architectural registers, x0 included
`define RV_NUM_REGS 32

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif

// File: tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
  parameter int period_ns = 100
) (
  output logic clk
);

  // free-running, first rising edge half a period after time zero
  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

endmodule

`default_nettype wire

// File: tb_rv_core.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_settings.svh"

module tb_rv_core;

  typedef rv_core_pkg::word_t    word_t;
  typedef rv_core_pkg::byte_en_t byte_en_t;
  typedef rv_isa_pkg::reg_idx_t  reg_idx_t;
  typedef rv_isa_pkg::funct3_t   funct3_t;
  typedef rv_isa_pkg::opcode_t   opcode_t;

  localparam int    clk_period   = 100;
  localparam int    reset_cycles = 5;
  localparam word_t seed         = 32'h12077b1f;
  // addi x0, x0, 0
  localparam word_t nop          = 32'h0000_0013;

  logic     clk;
  logic     rst;
  word_t    insn_from_imem;
  word_t    load_data_from_dmem;
  word_t    pc_to_imem;
  word_t    addr_to_dmem;
  word_t    store_data_to_dmem;
  byte_en_t store_we_to_dmem;
  logic     halt;

  // one entry per executed instruction in execution order
  word_t    insn_q[$];
  word_t    pc_q[$];
  word_t    ld_q[$];
  byte_en_t we_q[$];
  word_t    addr_q[$];
  word_t    data_q[$];
  logic     halt_q[$];

  word_t pc_model = `RV_RESET_PC;
  logic  table_ready = 1'b0;
  int    checks = 0;
  int    errors = 0;

  tb_clock_gen #(.period_ns(clk_period)) i_clock_gen (.clk(clk));

  rv_core i_dut (
    .clk                 (clk),
    .rst                 (rst),
    .insn_from_imem      (insn_from_imem),
    .load_data_from_dmem (load_data_from_dmem),
    .pc_to_imem          (pc_to_imem),
    .addr_to_dmem        (addr_to_dmem),
    .store_data_to_dmem  (store_data_to_dmem),
    .store_we_to_dmem    (store_we_to_dmem),
    .halt                (halt)
  );

  // instruction encoders
  function automatic word_t i_type(input opcode_t op, input funct3_t f3, input reg_idx_t rd,
                                   input reg_idx_t rs1, input word_t imm);
    return {imm[11:0], rs1, f3, rd, op};
  endfunction

  function automatic word_t r_type(input logic [6:0] f7, input funct3_t f3, input reg_idx_t rd,
                                   input reg_idx_t rs1, input reg_idx_t rs2);
    return {f7, rs2, rs1, f3, rd, rv_isa_pkg::op_reg};
  endfunction

  function automatic word_t s_type(input funct3_t f3, input reg_idx_t rs1, input reg_idx_t rs2,
                                   input word_t imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_isa_pkg::op_store};
  endfunction

  function automatic word_t b_type(input funct3_t f3, input reg_idx_t rs1, input reg_idx_t rs2,
                                   input word_t imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_isa_pkg::op_branch};
  endfunction

  function automatic word_t u_type(input opcode_t op, input reg_idx_t rd, input logic [19:0] imm);
    return {imm, rd, op};
  endfunction

  function automatic word_t j_type(input reg_idx_t rd, input word_t imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_isa_pkg::op_jal};
  endfunction

  task automatic emit(input word_t insn, input word_t ld, input byte_en_t we, input word_t addr,
                      input word_t data, input logic hlt, input word_t next_pc);
    insn_q.push_back(insn);
    pc_q.push_back(pc_model);
    ld_q.push_back(ld);
    we_q.push_back(we);
    addr_q.push_back(addr);
    data_q.push_back(data);
    halt_q.push_back(hlt);
    pc_model = next_pc;
  endtask

  task automatic plain_row(input word_t insn);
    emit(insn, '0, '0, '0, '0, 1'b0, pc_model + 4);
  endtask

  task automatic store_row(input word_t insn, input byte_en_t we, input word_t addr,
                           input word_t data);
    emit(insn, '0, we, addr, data, 1'b0, pc_model + 4);
  endtask

  // result lands in x5 and sw x5, 0(x0) shows it on the store port
  task automatic alu_then_store(input word_t insn, input word_t expected);
    plain_row(insn);
    store_row(s_type(rv_isa_pkg::f3_mem_w, 0, 5, 0), 4'b1111, '0, expected);
  endtask

  task automatic load_then_store(input funct3_t f3, input int off);
    word_t rnd;
    word_t lane;
    word_t expected;
    rnd  = $urandom;
    lane = rnd >> (8 * off);
    case (f3)
      rv_isa_pkg::f3_mem_b:  expected = {{24{lane[7]}}, lane[7:0]};
      rv_isa_pkg::f3_mem_bu: expected = {24'b0, lane[7:0]};
      rv_isa_pkg::f3_mem_h:  expected = {{16{lane[15]}}, lane[15:0]};
      rv_isa_pkg::f3_mem_hu: expected = {16'b0, lane[15:0]};
      default:               expected = rnd;
    endcase
    // base x4 = 0x200
    emit(i_type(rv_isa_pkg::op_load, f3, 5, 4, off), rnd, '0, 32'h200, '0, 1'b0, pc_model + 4);
    store_row(s_type(rv_isa_pkg::f3_mem_w, 0, 5, 0), 4'b1111, '0, expected);
  endtask

  // branch forward by 12 when taken
  task automatic branch_row(input funct3_t f3, input reg_idx_t rs1, input reg_idx_t rs2,
                            input logic taken);
    emit(b_type(f3, rs1, rs2, 12), '0, '0, '0, '0, 1'b0, taken ? pc_model + 12 : pc_model + 4);
  endtask

  task automatic build_program();
    word_t a;
    word_t b;
    word_t x3_val;
    word_t link;
    a      = -20;
    b      = 3;
    x3_val = {20'ha1b2c, 12'h000} + 32'h3d4;
    // x1 = a, x2 = b, x4 = load base, x3 = store pattern
    plain_row(i_type(rv_isa_pkg::op_imm, rv_isa_pkg::f3_add, 1, 0, a));
    plain_row(i_type(rv_isa_pkg::op_imm, rv_isa_pkg::f3_add, 2, 0, b));
    plain_row(i_type(rv_isa_pkg::op_imm, rv_isa_pkg::f3_add, 4, 0, 32'h200));
    plain_row(u_type(rv_isa_pkg::op_lui, 3, 20'ha1b2c));
    plain_row(i_type(rv_isa_pkg::op_imm, rv_isa_pkg::f3_add, 3, 3, 32'h3d4));

    alu_then_store(r_type(7'b0, rv_isa_pkg::f3_add, 5, 1, 2), a + b);
    alu_then_store(r_type(rv_isa_pkg::funct7_alt, rv_isa_pkg::f3_add, 5, 1, 2), a - b);
    alu_then_store(r_type(7'b0, rv_isa_pkg::f3_sll, 5, 1, 2), a << b[4:0]);
    alu_then_store(r_type(7'b0, rv_isa_pkg::f3_slt, 5, 1, 2), {31'b0, $signed(a) < $signed(b)});
    alu_then_store(r_type(7'b0, rv_isa_pkg::f3_sltu, 5, 1, 2), {31'b0, a < b});
    alu_then_store(r_type(7'b0, rv_isa_pkg::f3_xor, 5, 1, 2), a ^ b);
    alu_then_store(r_type(7'b0, rv_isa_pkg::f3_sr, 5, 1, 2), a >> b[4:0]);
    alu_then_store(r_type(rv_isa_pkg::funct7_alt, rv_isa_pkg::f3_sr, 5, 1, 2),
                   $signed(a) >>> b[4:0]);
    alu_then_store(r_type(7'b0, rv_isa_pkg::f3_or, 5, 1, 2), a | b);
    alu_then_store(r_type(7'b0, rv_isa_pkg::f3_and, 5, 1, 2), a & b);

    alu_then_store(i_type(rv_isa_pkg::op_imm, rv_isa_pkg::f3_add, 5, 1, 100), a + 100);
    alu_then_store(i_type(rv_isa_pkg::op_imm, rv_isa_pkg::f3_slt, 5, 1, -1),
                   {31'b0, $signed(a) < -1});
    alu_then_store(i_type(rv_isa_pkg::op_imm, rv_isa_pkg::f3_sltu, 5, 2, -1),
                   {31'b0, b < 32'hffff_ffff});
    alu_then_store(i_type(rv_isa_pkg::op_imm, rv_isa_pkg::f3_xor, 5, 1, 32'h00f), a ^ 32'h00f);
    alu_then_store(i_type(rv_isa_pkg::op_imm, rv_isa_pkg::f3_or, 5, 1, 32'h100), a | 32'h100);
    alu_then_store(i_type(rv_isa_pkg::op_imm, rv_isa_pkg::f3_and, 5, 1, 32'h7f0), a & 32'h7f0);
    alu_then_store(i_type(rv_isa_pkg::op_imm, rv_isa_pkg::f3_sll, 5, 2, 4), b << 4);
    alu_then_store(i_type(rv_isa_pkg::op_imm, rv_isa_pkg::f3_sr, 5, 1, 28), a >> 28);
    // srai carries funct7 0100000 in the upper immediate bits
    alu_then_store(i_type(rv_isa_pkg::op_imm, rv_isa_pkg::f3_sr, 5, 1, 32'h402),
                   $signed(a) >>> 2);
    alu_then_store(u_type(rv_isa_pkg::op_lui, 5, 20'h12345), {20'h12345, 12'h000});
    alu_then_store(u_type(rv_isa_pkg::op_auipc, 5, 20'h00001), pc_model + 32'h1000);

    for (int k = 0; k < 4; k++) begin
      store_row(s_type(rv_isa_pkg::f3_mem_b, 0, 3, 32'h100 + k), 4'b0001 << k, 32'h100,
                {4{x3_val[7:0]}});
    end
    for (int k = 0; k < 4; k += 2) begin
      store_row(s_type(rv_isa_pkg::f3_mem_h, 0, 3, 32'h100 + k), k == 0 ? 4'b0011 : 4'b1100,
                32'h100, {2{x3_val[15:0]}});
    end
    store_row(s_type(rv_isa_pkg::f3_mem_w, 0, 3, 32'h104), 4'b1111, 32'h104, x3_val);

    for (int k = 0; k < 4; k++) begin
      load_then_store(rv_isa_pkg::f3_mem_b, k);
      load_then_store(rv_isa_pkg::f3_mem_bu, k);
    end
    for (int k = 0; k < 4; k += 2) begin
      load_then_store(rv_isa_pkg::f3_mem_h, k);
      load_then_store(rv_isa_pkg::f3_mem_hu, k);
    end
    load_then_store(rv_isa_pkg::f3_mem_w, 0);

    // signed and unsigned order differ for x1 = -20 and x2 = 3
    branch_row(rv_isa_pkg::f3_beq, 1, 1, 1'b1);
    branch_row(rv_isa_pkg::f3_beq, 1, 2, 1'b0);
    branch_row(rv_isa_pkg::f3_bne, 1, 2, 1'b1);
    branch_row(rv_isa_pkg::f3_bne, 2, 2, 1'b0);
    branch_row(rv_isa_pkg::f3_blt, 1, 2, 1'b1);
    branch_row(rv_isa_pkg::f3_blt, 2, 1, 1'b0);
    branch_row(rv_isa_pkg::f3_bge, 2, 1, 1'b1);
    branch_row(rv_isa_pkg::f3_bge, 1, 2, 1'b0);
    branch_row(rv_isa_pkg::f3_bltu, 2, 1, 1'b1);
    branch_row(rv_isa_pkg::f3_bltu, 1, 2, 1'b0);
    branch_row(rv_isa_pkg::f3_bgeu, 1, 2, 1'b1);
    branch_row(rv_isa_pkg::f3_bgeu, 2, 1, 1'b0);

    link = pc_model + 4;
    emit(j_type(6, 16), '0, '0, '0, '0, 1'b0, pc_model + 16);
    store_row(s_type(rv_isa_pkg::f3_mem_w, 0, 6, 0), 4'b1111, '0, link);
    link = pc_model + 4;
    emit(i_type(rv_isa_pkg::op_jalr, 3'b000, 7, 4, 32'h11), '0, '0, '0, '0, 1'b0,
         (32'h200 + 32'h11) & ~32'h1);
    store_row(s_type(rv_isa_pkg::f3_mem_w, 0, 7, 0), 4'b1111, '0, link);

    // ecall raises halt and the ordinary instruction after it drops halt again
    emit(32'h0000_0073, '0, '0, '0, '0, 1'b1, pc_model + 4);
    plain_row(nop);
  endtask

  task automatic compare(input string name, input word_t expected, input word_t actual);
    checks++;
    value_matches: assert (actual === expected) else begin
      errors++;
      $display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic check_row(input int i);
    compare("pc_to_imem", pc_q[i], pc_to_imem);
    compare("store_we_to_dmem", we_q[i], store_we_to_dmem);
    compare("halt", halt_q[i], halt);
    if (we_q[i] != '0 || addr_q[i] != '0) begin
      compare("addr_to_dmem", addr_q[i], addr_to_dmem);
    end
    if (we_q[i] != '0) begin
      compare("store_data_to_dmem", data_q[i], store_data_to_dmem);
    end
  endtask

  initial begin
    rst                 = 1'b1;
    insn_from_imem      = nop;
    load_data_from_dmem = '0;
    void'($urandom(seed));
    build_program();
    table_ready = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    // drive on the falling edge and check just before the next rising edge
    for (int i = 0; i < insn_q.size(); i++) begin
      insn_from_imem      = insn_q[i];
      load_data_from_dmem = ld_q[i];
      #(clk_period * 2 / 5);
      check_row(i);
      @(negedge clk);
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial begin
    wait (table_ready);
    #((reset_cycles + insn_q.size() + 10) * clk_period);
    $display("timeout: the instruction table did not complete in the expected run time");
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+.
rv_isa_pkg.sv
rv_core_pkg.sv
rv_decoder.sv
rv_regfile.sv
rv_pc_unit.sv
rv_execute.sv
rv_lsu.sv
rv_core.sv
tb_clock_gen.sv
tb_rv_core.sv
